/* source/circle_pkg.sv */
package circle_pkg;

    // Frame buffer geometry
    localparam int scr_width  = 640;
    localparam int scr_height = 480;

    // Keeps the octant step terms inside 12 bits
    localparam int max_radius = 255;

    // Screen coordinate, centre or radius
    typedef logic [9:0] coord_t;

    // Mirrored point before clipping, may fall off either edge
    typedef logic signed [10:0] scoord_t;

    // RGB 4:4:4
    typedef logic [11:0] color_t;

    // Linear address, y * scr_width + x
    typedef logic [18:0] fb_addr_t;

    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t r;
        color_t color;
    } circle_cmd_t;

    typedef struct packed {
        scoord_t x;
        scoord_t y;
    } point_t;

    // pt[0] is octant 0
    typedef struct packed {
        point_t [7:0] pt;
        color_t       color;
    } octant_set_t;

    typedef struct packed {
        fb_addr_t addr;
        color_t   color;
    } pixel_t;

endpackage

/* source/circle_drawer.sv */
`timescale 1ns/100ps

module circle_drawer (
    input  logic                      clk,
    input  logic                      rst_,
    input  circle_pkg::circle_cmd_t   cmd,
    input  logic                      cmd_rts,
    output logic                      cmd_rtr,
    output circle_pkg::octant_set_t   set,
    output logic                      set_rts,
    input  logic                      set_rtr
);

    typedef enum logic [1:0] {
        st_start,
        st_init,
        st_draw,
        st_end
    } drawer_state_t;

    drawer_state_t state;

    // Latched command
    circle_pkg::coord_t cx;
    circle_pkg::coord_t cy;
    circle_pkg::color_t col;

    // Octant walk position
    circle_pkg::coord_t x;
    circle_pkg::coord_t y;

    // Midpoint step terms
    logic signed [11:0] dx;
    logic signed [11:0] dy;
    logic signed [11:0] err;

    // Decision term, two bits wider than the step terms
    logic signed [13:0] decide;
    logic               step_x;

    logic cmd_xfc;
    logic set_xfc;

    assign cmd_rtr = (state == st_start);
    assign set_rts = (state == st_draw);

    assign cmd_xfc = cmd_rts & cmd_rtr;
    assign set_xfc = set_rts & set_rtr;

    always_comb
    begin
        decide = 14'(err) + 14'(dy);
        decide = (decide <<< 1) + 14'(dx);
        step_x = (decide > 0);
    end

    always_ff @(posedge clk or negedge rst_)
    begin
        if (!rst_)
        begin
            state <= st_start;
        end
        else
        begin
            case (state)
                st_start:
                    if (cmd_xfc)
                        state <= st_init;
                st_init:
                    state <= st_draw;
                st_draw:
                    // Stop once the walk has crossed the diagonal or reached the centre
                    if (set_xfc)
                        state <= (x >= y && x != '0) ? st_draw : st_end;
                default:
                    state <= st_start;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (cmd_xfc)
        begin
            cx  <= cmd.x0;
            cy  <= cmd.y0;
            col <= cmd.color;
            x   <= cmd.r;
            y   <= '0;
            dx  <= 12'sd1 - $signed({1'b0, cmd.r, 1'b0});
            dy  <= 12'sd1;
            err <= '0;
        end
        else if (set_xfc)
        begin
            if (step_x)
            begin
                x   <= x - 1'b1;
                err <= err + dx;
                dx  <= dx + 12'sd2;
            end
            else
            begin
                y   <= y + 1'b1;
                err <= err + dy;
                dy  <= dy + 12'sd2;
            end
        end
    end

    // Mirror the current step into all eight octants, signed so clipping sees the edges
    always_comb
    begin
        circle_pkg::scoord_t sx0;
        circle_pkg::scoord_t sy0;
        circle_pkg::scoord_t sx;
        circle_pkg::scoord_t sy;

        sx0 = circle_pkg::scoord_t'({1'b0, cx});
        sy0 = circle_pkg::scoord_t'({1'b0, cy});
        sx  = circle_pkg::scoord_t'({1'b0, x});
        sy  = circle_pkg::scoord_t'({1'b0, y});

        set.pt[0].x = sx0 + sx;
        set.pt[0].y = sy0 + sy;
        set.pt[1].x = sx0 + sy;
        set.pt[1].y = sy0 + sx;
        set.pt[2].x = sx0 - sy;
        set.pt[2].y = sy0 + sx;
        set.pt[3].x = sx0 - sx;
        set.pt[3].y = sy0 + sy;
        set.pt[4].x = sx0 - sx;
        set.pt[4].y = sy0 - sy;
        set.pt[5].x = sx0 - sy;
        set.pt[5].y = sy0 - sx;
        set.pt[6].x = sx0 + sy;
        set.pt[6].y = sy0 - sx;
        set.pt[7].x = sx0 + sx;
        set.pt[7].y = sy0 - sy;
        set.color   = col;
    end

endmodule

/* source/octant_expander.sv */
`timescale 1ns/100ps

module octant_expander (
    input  logic                      clk,
    input  logic                      rst_,
    input  circle_pkg::octant_set_t   set,
    input  logic                      set_rts,
    output logic                      set_rtr,
    output circle_pkg::pixel_t        pixel,
    output logic                      pixel_rts,
    input  logic                      pixel_rtr
);

    // Held set and the points of it still to be sent
    circle_pkg::octant_set_t set_q;
    logic [7:0]              pending;

    // Survivors of the incoming set
    logic [7:0] on_screen;

    // Lowest pending point
    logic [2:0]          idx;
    circle_pkg::point_t  sel;
    circle_pkg::fb_addr_t xa;
    circle_pkg::fb_addr_t ya;

    logic set_xfc;
    logic pixel_xfc;

    // Free again once every survivor has gone
    assign set_rtr   = (pending == 8'd0);
    assign pixel_rts = (pending != 8'd0);

    assign set_xfc   = set_rts & set_rtr;
    assign pixel_xfc = pixel_rts & pixel_rtr;

    always_comb
    begin
        for (int i = 0; i < 8; i++)
        begin
            on_screen[i] = (set.pt[i].x >= 0) &&
                           (set.pt[i].x < circle_pkg::scr_width) &&
                           (set.pt[i].y >= 0) &&
                           (set.pt[i].y < circle_pkg::scr_height);
        end
    end

    // Priority pick, octant 0 first
    always_comb
    begin
        idx = 3'd0;
        for (int i = 7; i >= 0; i--)
        begin
            if (pending[i])
                idx = 3'(i);
        end
    end

    assign sel = set_q.pt[idx];

    // Only survivors reach here, so the sign bits are clear
    assign xa = circle_pkg::fb_addr_t'(sel.x[9:0]);
    assign ya = circle_pkg::fb_addr_t'(sel.y[9:0]);

    // 640 * y as 512 * y + 128 * y
    assign pixel.addr  = (ya << 9) + (ya << 7) + xa;
    assign pixel.color = set_q.color;

    always_ff @(posedge clk or negedge rst_)
    begin
        if (!rst_)
        begin
            pending <= 8'd0;
        end
        else
        begin
            if (set_xfc)
                pending <= on_screen;
            else if (pixel_xfc)
                pending <= pending & ~(8'd1 << idx);
        end
    end

    always_ff @(posedge clk)
    begin
        if (set_xfc)
            set_q <= set;
    end

endmodule

/* source/pixel_fifo.sv */
`timescale 1ns/100ps

module pixel_fifo #(
    parameter int depth = 4
) (
    input  logic                  clk,
    input  logic                  rst_,
    input  circle_pkg::pixel_t    wr_data,
    input  logic                  wr_rts,
    output logic                  wr_rtr,
    output circle_pkg::pixel_t    rd_data,
    output logic                  rd_rts,
    input  logic                  rd_rtr
);

    circle_pkg::pixel_t mem [depth];

    logic [$clog2(depth)-1:0]   wr_ptr;
    logic [$clog2(depth)-1:0]   rd_ptr;
    logic [$clog2(depth+1)-1:0] count;

    logic full;
    logic wr_xfc;
    logic rd_xfc;

    assign full = (count == $bits(count)'(depth));

    // A read in the same cycle frees the slot for a write
    assign wr_rtr  = !full || rd_rtr;
    assign rd_rts  = (count != '0);
    assign rd_data = mem[rd_ptr];

    assign wr_xfc = wr_rts & wr_rtr;
    assign rd_xfc = rd_rts & rd_rtr;

    always_ff @(posedge clk or negedge rst_)
    begin
        if (!rst_)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_xfc)
                wr_ptr <= (wr_ptr == $bits(wr_ptr)'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_xfc)
                rd_ptr <= (rd_ptr == $bits(rd_ptr)'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({wr_xfc, rd_xfc})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_xfc)
            mem[wr_ptr] <= wr_data;
    end

endmodule

/* source/circle_raster.sv */
`timescale 1ns/100ps

module circle_raster (
    input  logic                      clk,
    input  logic                      rst_,
    input  circle_pkg::circle_cmd_t   cmd,
    input  logic                      cmd_rts,
    output logic                      cmd_rtr,
    output circle_pkg::pixel_t        pix,
    output logic                      pix_rts,
    input  logic                      pix_rtr
);

    // Drawer to expander
    circle_pkg::octant_set_t set;
    logic                    set_rts;
    logic                    set_rtr;

    // Expander to FIFO
    circle_pkg::pixel_t exp_pixel;
    logic               exp_rts;
    logic               exp_rtr;

    circle_drawer u_drawer (
        .clk     (clk),
        .rst_    (rst_),
        .cmd     (cmd),
        .cmd_rts (cmd_rts),
        .cmd_rtr (cmd_rtr),
        .set     (set),
        .set_rts (set_rts),
        .set_rtr (set_rtr)
    );

    octant_expander u_expander (
        .clk       (clk),
        .rst_      (rst_),
        .set       (set),
        .set_rts   (set_rts),
        .set_rtr   (set_rtr),
        .pixel     (exp_pixel),
        .pixel_rts (exp_rts),
        .pixel_rtr (exp_rtr)
    );

    // Decouples the expander from frame-buffer back-pressure
    pixel_fifo #(
        .depth (4)
    ) u_fifo (
        .clk     (clk),
        .rst_    (rst_),
        .wr_data (exp_pixel),
        .wr_rts  (exp_rts),
        .wr_rtr  (exp_rtr),
        .rd_data (pix),
        .rd_rts  (pix_rts),
        .rd_rtr  (pix_rtr)
    );

endmodule

/* testbench/circle_raster_chk.sv */
`timescale 1ns/100ps

module circle_raster_chk (
    input logic               clk,
    input logic               rst_,
    input logic               cmd_rtr,
    input circle_pkg::pixel_t pix,
    input logic               pix_rts,
    input logic               pix_rtr
);

    // Offered pixel held until taken
    assert property (@(posedge clk) disable iff (!rst_)
        pix_rts && !pix_rtr |=> pix_rts && $stable(pix))
    else $error("pix changed or was withdrawn before pix_rtr");

    // Idle straight out of reset
    assert property (@(posedge clk)
        $rose(rst_) |-> cmd_rtr && !pix_rts)
    else $error("cmd_rtr low or pix_rts high after reset release");

    // Frame buffer holds 640 x 480 pixels
    assert property (@(posedge clk) disable iff (!rst_)
        pix_rts && pix_rtr |-> pix.addr < circle_pkg::scr_width * circle_pkg::scr_height)
    else $error("pixel address beyond the frame buffer");

endmodule

bind circle_raster circle_raster_chk u_chk (.*);

/* testbench/circle_raster_tb.sv */
`timescale 1ns/100ps

module circle_raster_tb;

    localparam int n_tests = 10;

    string test_name [n_tests] = '{
        "radius0_centre", "r5_inside", "r40_inside", "r120_inside", "r200_inside",
        "r255_clipped", "corner_top_left", "corner_bottom_right", "edge_left", "edge_bottom"
    };

    // x0, y0, r, colour
    circle_pkg::circle_cmd_t test_cmd [n_tests] = '{
        {10'd320, 10'd240, 10'd0,   12'hf00},
        {10'd100, 10'd100, 10'd5,   12'h0f0},
        {10'd320, 10'd240, 10'd40,  12'h00f},
        {10'd300, 10'd250, 10'd120, 12'h123},
        {10'd320, 10'd240, 10'd200, 12'h456},
        {10'd320, 10'd240, 10'd255, 12'h789},
        {10'd0,   10'd0,   10'd30,  12'habc},
        {10'd639, 10'd479, 10'd60,  12'hdef},
        {10'd5,   10'd200, 10'd50,  12'h5a5},
        {10'd400, 10'd470, 10'd100, 12'ha5a}
    };

    logic                    clk;
    logic                    rst_;
    circle_pkg::circle_cmd_t cmd;
    logic                    cmd_rts;
    logic                    cmd_rtr;
    circle_pkg::pixel_t      pix;
    logic                    pix_rts;
    logic                    pix_rtr;

    circle_pkg::pixel_t exp_pix [$];
    int                 exp_test [$];
    int                 errors = 0;
    int                 checked = 0;
    logic [31:0]        lcg_state = 32'hf4c5;

    circle_raster u_circle_raster (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checked++;
        if (expected !== actual)
        begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Midpoint octant walk, mirroring and clipping for one command
    task automatic model_circle(input int t);
        circle_pkg::circle_cmd_t c;
        circle_pkg::coord_t      x;
        circle_pkg::coord_t      y;
        logic signed [11:0]      dx;
        logic signed [11:0]      dy;
        logic signed [11:0]      err;
        circle_pkg::pixel_t      p;
        int                      px [8];
        int                      py [8];
        int                      xi;
        int                      yi;
        logic                    more;
        c = test_cmd[t];
        x = c.r;
        y = '0;
        dx = 12'(1 - 2 * int'(c.r));
        dy = 12'sd1;
        err = '0;
        more = 1'b1;
        while (more)
        begin
            xi = int'(x);
            yi = int'(y);
            px = '{c.x0 + xi, c.x0 + yi, c.x0 - yi, c.x0 - xi,
                   c.x0 - xi, c.x0 - yi, c.x0 + yi, c.x0 + xi};
            py = '{c.y0 + yi, c.y0 + xi, c.y0 + xi, c.y0 + yi,
                   c.y0 - yi, c.y0 - xi, c.y0 - xi, c.y0 - yi};
            for (int k = 0; k < 8; k++)
            begin
                if (px[k] >= 0 && px[k] < 640 && py[k] >= 0 && py[k] < 480)
                begin
                    p.addr  = circle_pkg::fb_addr_t'(py[k] * 640 + px[k]);
                    p.color = c.color;
                    exp_pix.push_back(p);
                    exp_test.push_back(t);
                end
            end
            // A walk that reaches the centre ends there, so radius 0 gives one set
            more = (x >= y) && (x != 10'd0);
            if (2 * (int'(err) + int'(dy)) + int'(dx) > 0)
            begin
                x = x - 10'd1;
                err = err + dx;
                dx = dx + 12'sd2;
            end
            else
            begin
                y = y + 10'd1;
                err = err + dy;
                dy = dy + 12'sd2;
            end
        end
    endtask

    task automatic send_command(input int t);
        @(negedge clk);
        cmd = test_cmd[t];
        cmd_rts = 1'b1;
        while (!cmd_rtr)
            @(negedge clk);
        @(posedge clk);
    endtask

    task automatic finish_run;
        $display("Errors: %0d, checks: %0d", errors, checked);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    endtask

    // Random back-pressure, ready about three cycles in four
    always @(negedge clk)
    begin
        lcg_state = lcg_next(lcg_state);
        pix_rtr = (lcg_state[31:30] != 2'b00);
    end

    always @(posedge clk)
    begin
        if (rst_ && pix_rts && pix_rtr)
        begin
            if (exp_pix.size() == 0)
            begin
                errors++;
                $display("Pixel at address %0d arrived when none was expected", pix.addr);
            end
            else
                check_value(test_name[exp_test.pop_front()], 32'(exp_pix.pop_front()),
                            32'(pix));
        end
    end

    initial
    begin
        repeat (n_tests * 2500) @(posedge clk);
        $display("Timeout: the pixel stream did not finish within %0d cycles",
                 n_tests * 2500);
        errors++;
        finish_run();
    end

    initial
    begin
        clk = 1'b0;
        rst_ = 1'b0;
        cmd = '0;
        cmd_rts = 1'b0;
        pix_rtr = 1'b0;
        for (int t = 0; t < n_tests; t++)
            model_circle(t);
        repeat (5) @(negedge clk);
        rst_ = 1'b1;
        // Idle until the first command
        repeat (4)
        begin
            @(negedge clk);
            check_value("idle_after_reset", 32'b10, {30'b0, cmd_rtr, pix_rts});
        end
        // Back to back, each waits only for its own transfer
        for (int t = 0; t < n_tests; t++)
            send_command(t);
        @(negedge clk);
        cmd_rts = 1'b0;
        while (exp_pix.size() != 0)
            @(negedge clk);
        repeat (20)
        begin
            @(negedge clk);
            check_value("drained", 32'b0, {31'b0, pix_rts});
        end
        finish_run();
    end

endmodule

/* circle_raster.f */
source/circle_pkg.sv
source/circle_drawer.sv
source/octant_expander.sv
source/pixel_fifo.sv
source/circle_raster.sv
testbench/circle_raster_chk.sv
testbench/circle_raster_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module circle_raster_tb \
    -f circle_raster.f \
    -o circle_raster_sim

./obj_dir/circle_raster_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
